/* hw/core_consts.svh */
`ifndef CORE_CONSTS_SVH
`define CORE_CONSTS_SVH

// Data path and PC width
`define XLEN 32

// Instruction word width
`define INST_LEN 32

// Register index width, x0..x31
`define REG_ADDR_W 5

`endif

/* hw/core_pkg.sv */
`default_nettype none
`include "core_consts.svh"

package core_pkg;

  typedef enum logic [3:0] {
    ADD,
    SUB,
    AND,
    OR,
    XOR,
    SLT,
    SLL,
    SRL,
    PASS_B  // LUI
  } alu_op_e;

  typedef enum logic [1:0] {
    RS2,
    IMM,
    FOUR    // Link value
  } src2_sel_e;

  typedef union packed {
    struct packed {
      logic [6:0]             funct7;
      logic [`REG_ADDR_W-1:0] rs2;
      logic [`REG_ADDR_W-1:0] rs1;
      logic [2:0]             funct3;
      logic [`REG_ADDR_W-1:0] rd;
      logic [6:0]             opcode;
    } r;
    struct packed {
      logic [11:0]            imm12;
      logic [`REG_ADDR_W-1:0] rs1;
      logic [2:0]             funct3;
      logic [`REG_ADDR_W-1:0] rd;
      logic [6:0]             opcode;
    } i;
  } instr_u;

  localparam logic [6:0] OP     = 7'b0110011;
  localparam logic [6:0] OP_IMM = 7'b0010011;
  localparam logic [6:0] LUI    = 7'b0110111;
  localparam logic [6:0] JAL    = 7'b1101111;
  localparam logic [6:0] JALR   = 7'b1100111;
  localparam logic [6:0] BRANCH = 7'b1100011;

endpackage

`default_nettype wire

/* hw/reg_file.sv */
`timescale 1ns/1ps
`default_nettype none
`include "core_consts.svh"

module reg_file (
  input  logic                   clk,
  input  logic                   reset_i,
  input  logic                   we_i,
  input  logic [`REG_ADDR_W-1:0] waddr_i,
  input  logic [`XLEN-1:0]       wdata_i,
  input  logic [`REG_ADDR_W-1:0] raddr1_i,
  input  logic [`REG_ADDR_W-1:0] raddr2_i,
  output logic [`XLEN-1:0]       rdata1_o,
  output logic [`XLEN-1:0]       rdata2_o
);

  logic [`XLEN-1:0] regs [1:31];  // x0 has no storage

  always_ff @(posedge clk) begin
    if (reset_i) begin
      for (int k = 1; k < 32; k++) begin
        regs[k] <= '0;
      end
    end else if (we_i && waddr_i != '0) begin
      regs[waddr_i] <= wdata_i;
    end
  end

  // Same-cycle write is visible on the read ports
  always_comb begin
    if (raddr1_i == '0) rdata1_o = '0;
    else if (we_i && waddr_i == raddr1_i) rdata1_o = wdata_i;
    else rdata1_o = regs[raddr1_i];
    if (raddr2_i == '0) rdata2_o = '0;
    else if (we_i && waddr_i == raddr2_i) rdata2_o = wdata_i;
    else rdata2_o = regs[raddr2_i];
  end

  // Writeback filters x0 before it reaches the port
  a_no_x0_write: assert property (@(posedge clk) disable iff (reset_i)
    !(we_i && waddr_i == '0));

endmodule

`default_nettype wire

/* hw/id_decode.sv */
`timescale 1ns/1ps
`default_nettype none
`include "core_consts.svh"

module id_decode import core_pkg::*; (
  input  logic [`XLEN-1:0]       pc_i,
  input  instr_u                 instr_i,
  input  logic                   valid_i,
  output logic [`REG_ADDR_W-1:0] rs1_idx_o,
  output logic [`REG_ADDR_W-1:0] rs2_idx_o,
  input  logic [`XLEN-1:0]       rdata1_i,
  input  logic [`XLEN-1:0]       rdata2_i,
  input  logic                   fwd_en_i,
  input  logic [`REG_ADDR_W-1:0] fwd_rd_i,
  input  logic [`XLEN-1:0]       fwd_data_i,
  output logic [`XLEN-1:0]       rs1_o,
  output logic [`XLEN-1:0]       rs2_o,
  output logic [`XLEN-1:0]       imm_o,
  output alu_op_e                aluop_o,
  output logic                   src1pc_o,
  output src2_sel_e              src2sel_o,
  output logic                   is_jal_o,
  output logic                   is_jalr_o,
  output logic                   is_brc_o,
  output logic [2:0]             brc_funct3_o,
  output logic                   wben_o,
  output logic [`REG_ADDR_W-1:0] rd_o,
  output logic                   trap_o,
  output logic                   valid_o,
  output logic [`XLEN-1:0]       pc_o
);

  logic [`INST_LEN-1:0] word;
  logic [`XLEN-1:0]     imm_i_type;
  logic [`XLEN-1:0]     imm_u_type;
  logic [`XLEN-1:0]     imm_j_type;
  logic [`XLEN-1:0]     imm_b_type;

  assign word       = instr_i;
  assign imm_i_type = {{(`XLEN-12){instr_i.i.imm12[11]}}, instr_i.i.imm12};
  assign imm_u_type = {word[31:12], 12'b0};
  assign imm_j_type = {{(`XLEN-20){word[31]}}, word[19:12], word[20], word[30:21], 1'b0};
  assign imm_b_type = {{(`XLEN-12){word[31]}}, word[7], word[30:25], word[11:8], 1'b0};

  assign rs1_idx_o    = instr_i.r.rs1;
  assign rs2_idx_o    = instr_i.r.rs2;
  assign rd_o         = instr_i.r.rd;
  assign brc_funct3_o = instr_i.r.funct3;
  assign valid_o      = valid_i;
  assign pc_o         = pc_i;

  // Result of the instruction in EX wins over the register file
  assign rs1_o = (fwd_en_i && fwd_rd_i == rs1_idx_o && rs1_idx_o != '0) ? fwd_data_i : rdata1_i;
  assign rs2_o = (fwd_en_i && fwd_rd_i == rs2_idx_o && rs2_idx_o != '0) ? fwd_data_i : rdata2_i;

  always_comb begin
    aluop_o   = ADD;
    src1pc_o  = 1'b0;
    src2sel_o = RS2;
    imm_o     = '0;
    is_jal_o  = 1'b0;
    is_jalr_o = 1'b0;
    is_brc_o  = 1'b0;
    wben_o    = 1'b0;
    trap_o    = 1'b0;
    case (instr_i.r.opcode)
      OP: begin
        wben_o = 1'b1;
        case (instr_i.r.funct3)
          3'b000:  aluop_o = instr_i.r.funct7[5] ? SUB : ADD;
          3'b001:  aluop_o = SLL;
          3'b010:  aluop_o = SLT;
          3'b100:  aluop_o = XOR;
          3'b101:  aluop_o = SRL;
          3'b110:  aluop_o = OR;
          3'b111:  aluop_o = AND;
          default: aluop_o = ADD;
        endcase
      end
      OP_IMM: begin
        wben_o    = 1'b1;
        src2sel_o = IMM;
        imm_o     = imm_i_type;
        case (instr_i.i.funct3)
          3'b010:  aluop_o = SLT;
          3'b100:  aluop_o = XOR;
          3'b110:  aluop_o = OR;
          3'b111:  aluop_o = AND;
          default: aluop_o = ADD;
        endcase
      end
      LUI: begin
        wben_o    = 1'b1;
        aluop_o   = PASS_B;
        src2sel_o = IMM;
        imm_o     = imm_u_type;
      end
      JAL, JALR: begin
        wben_o    = 1'b1;
        src1pc_o  = 1'b1;   // Link is pc + 4
        src2sel_o = FOUR;
        is_jal_o  = (instr_i.r.opcode == JAL);
        is_jalr_o = (instr_i.r.opcode == JALR);
        imm_o     = (instr_i.r.opcode == JAL) ? imm_j_type : imm_i_type;
      end
      BRANCH: begin
        is_brc_o = 1'b1;
        imm_o    = imm_b_type;
      end
      default: trap_o = 1'b1;
    endcase
  end

endmodule

`default_nettype wire

/* hw/ex_reg.sv */
`timescale 1ns/1ps
`default_nettype none
`include "core_consts.svh"

module ex_reg import core_pkg::*; (
  input  logic                   clk,
  input  logic                   reset_i,
  input  logic                   stall_i,
  input  logic                   flush_i,
  input  logic                   valid_i,
  input  logic [`XLEN-1:0]       pc_i,
  input  logic [`XLEN-1:0]       rs1_i,
  input  logic [`XLEN-1:0]       rs2_i,
  input  logic [`XLEN-1:0]       imm_i,
  input  alu_op_e                aluop_i,
  input  logic                   src1pc_i,
  input  src2_sel_e              src2sel_i,
  input  logic                   is_jal_i,
  input  logic                   is_jalr_i,
  input  logic                   is_brc_i,
  input  logic [2:0]             brc_funct3_i,
  input  logic                   wben_i,
  input  logic [`REG_ADDR_W-1:0] rd_i,
  input  logic                   trap_i,
  output logic                   valid_o,
  output logic [`XLEN-1:0]       pc_o,
  output logic [`XLEN-1:0]       rs1_o,
  output logic [`XLEN-1:0]       rs2_o,
  output logic [`XLEN-1:0]       imm_o,
  output alu_op_e                aluop_o,
  output logic                   src1pc_o,
  output src2_sel_e              src2sel_o,
  output logic                   is_jal_o,
  output logic                   is_jalr_o,
  output logic                   is_brc_o,
  output logic [2:0]             brc_funct3_o,
  output logic                   wben_o,
  output logic [`REG_ADDR_W-1:0] rd_o,
  output logic                   trap_o
);

  always_ff @(posedge clk) begin
    if (reset_i) begin
      valid_o      <= 1'b0;
      pc_o         <= '0;
      rs1_o        <= '0;
      rs2_o        <= '0;
      imm_o        <= '0;
      aluop_o      <= ADD;
      src1pc_o     <= 1'b0;
      src2sel_o    <= RS2;
      is_jal_o     <= 1'b0;
      is_jalr_o    <= 1'b0;
      is_brc_o     <= 1'b0;
      brc_funct3_o <= '0;
      wben_o       <= 1'b0;
      rd_o         <= '0;
      trap_o       <= 1'b0;
    end else if (!stall_i) begin
      // Flush only kills the fields that can cause side effects
      valid_o      <= flush_i ? 1'b0 : valid_i;
      pc_o         <= flush_i ? '0   : pc_i;
      is_jal_o     <= flush_i ? 1'b0 : is_jal_i;
      is_jalr_o    <= flush_i ? 1'b0 : is_jalr_i;
      is_brc_o     <= flush_i ? 1'b0 : is_brc_i;
      wben_o       <= flush_i ? 1'b0 : wben_i;
      trap_o       <= flush_i ? 1'b0 : trap_i;
      rs1_o        <= rs1_i;
      rs2_o        <= rs2_i;
      imm_o        <= imm_i;
      aluop_o      <= aluop_i;
      src1pc_o     <= src1pc_i;
      src2sel_o    <= src2sel_i;
      brc_funct3_o <= brc_funct3_i;
      rd_o         <= rd_i;
    end
  end

  a_flush_bubble: assert property (@(posedge clk) disable iff (reset_i)
    (flush_i && !stall_i) |=> !valid_o);

endmodule

`default_nettype wire

/* hw/ex_alu.sv */
`timescale 1ns/1ps
`default_nettype none
`include "core_consts.svh"

module ex_alu import core_pkg::*; (
  input  logic                   clk,
  input  logic                   reset_i,
  input  logic                   valid_i,
  input  logic [`XLEN-1:0]       pc_i,
  input  logic [`XLEN-1:0]       rs1_i,
  input  logic [`XLEN-1:0]       rs2_i,
  input  logic [`XLEN-1:0]       imm_i,
  input  alu_op_e                aluop_i,
  input  logic                   src1pc_i,
  input  src2_sel_e              src2sel_i,
  input  logic                   is_jal_i,
  input  logic                   is_jalr_i,
  input  logic                   is_brc_i,
  input  logic [2:0]             brc_funct3_i,
  input  logic                   wben_i,
  input  logic [`REG_ADDR_W-1:0] rd_i,
  input  logic                   trap_i,
  output logic                   res_valid_o,
  output logic [`REG_ADDR_W-1:0] res_rd_o,
  output logic [`XLEN-1:0]       res_data_o,
  output logic                   res_we_o,
  output logic                   fwd_en_o,
  output logic [`REG_ADDR_W-1:0] fwd_rd_o,
  output logic [`XLEN-1:0]       fwd_data_o,
  output logic                   redirect_valid_o,
  output logic [`XLEN-1:0]       redirect_pc_o,
  output logic                   trap_valid_o,
  output logic [`XLEN-1:0]       trap_pc_o
);

  logic [`XLEN-1:0] op_a;
  logic [`XLEN-1:0] op_b;
  logic [`XLEN-1:0] alu_res;
  logic [`XLEN-1:0] jalr_sum;
  logic [4:0]       shamt;
  logic             br_cond;

  assign op_a  = src1pc_i ? pc_i : rs1_i;
  assign shamt = op_b[4:0];

  always_comb begin
    case (src2sel_i)
      RS2:     op_b = rs2_i;
      IMM:     op_b = imm_i;
      FOUR:    op_b = `XLEN'd4;
      default: op_b = '0;
    endcase
  end

  always_comb begin
    case (aluop_i)
      ADD:     alu_res = op_a + op_b;
      SUB:     alu_res = op_a - op_b;
      AND:     alu_res = op_a & op_b;
      OR:      alu_res = op_a | op_b;
      XOR:     alu_res = op_a ^ op_b;
      SLT:     alu_res = {{(`XLEN-1){1'b0}}, $signed(op_a) < $signed(op_b)};
      SLL:     alu_res = op_a << shamt;
      SRL:     alu_res = op_a >> shamt;
      PASS_B:  alu_res = op_b;
      default: alu_res = '0;
    endcase
  end

  always_comb begin
    case (brc_funct3_i)
      3'b000:  br_cond = (rs1_i == rs2_i);
      3'b001:  br_cond = (rs1_i != rs2_i);
      3'b100:  br_cond = $signed(rs1_i) < $signed(rs2_i);
      3'b101:  br_cond = $signed(rs1_i) >= $signed(rs2_i);
      default: br_cond = 1'b0;
    endcase
  end

  assign jalr_sum         = rs1_i + imm_i;
  assign redirect_valid_o = valid_i && (is_jal_i || is_jalr_i || (is_brc_i && br_cond));
  assign redirect_pc_o    = is_jalr_i ? {jalr_sum[`XLEN-1:1], 1'b0} : pc_i + imm_i;

  assign trap_valid_o = valid_i && trap_i;
  assign trap_pc_o    = pc_i;

  assign res_valid_o = valid_i;
  assign res_we_o    = valid_i && wben_i;
  assign res_rd_o    = rd_i;
  assign res_data_o  = alu_res;

  assign fwd_en_o   = res_we_o;
  assign fwd_rd_o   = res_rd_o;
  assign fwd_data_o = res_data_o;

  // Illegal opcodes never redirect or write back
  a_trap_quiet: assert property (@(posedge clk) disable iff (reset_i)
    trap_valid_o |-> !redirect_valid_o && !res_we_o);

endmodule

`default_nettype wire

/* hw/wb_stage.sv */
`timescale 1ns/1ps
`default_nettype none
`include "core_consts.svh"

module wb_stage (
  input  logic                   clk,
  input  logic                   reset_i,
  input  logic                   hold_i,
  input  logic                   res_valid_i,
  input  logic                   res_we_i,
  input  logic [`REG_ADDR_W-1:0] res_rd_i,
  input  logic [`XLEN-1:0]       res_data_i,
  output logic                   rf_we_o,
  output logic [`REG_ADDR_W-1:0] rf_waddr_o,
  output logic [`XLEN-1:0]       rf_wdata_o,
  output logic                   wb_valid_o,
  output logic [`REG_ADDR_W-1:0] wb_rd_o,
  output logic [`XLEN-1:0]       wb_data_o
);

  logic                   we_q;
  logic [`REG_ADDR_W-1:0] rd_q;
  logic [`XLEN-1:0]       data_q;

  always_ff @(posedge clk) begin
    if (reset_i) begin
      we_q <= 1'b0;
    end else begin
      // Bubble while held, EX keeps the instruction for later
      we_q <= !hold_i && res_valid_i && res_we_i && (res_rd_i != '0);
    end
  end

  always_ff @(posedge clk) begin
    rd_q   <= res_rd_i;
    data_q <= res_data_i;
  end

  assign rf_we_o    = we_q;
  assign rf_waddr_o = rd_q;
  assign rf_wdata_o = data_q;

  assign wb_valid_o = we_q;
  assign wb_rd_o    = rd_q;
  assign wb_data_o  = data_q;

endmodule

`default_nettype wire

/* hw/ex_subsys.sv */
`timescale 1ns/1ps
`default_nettype none
`include "core_consts.svh"

module ex_subsys import core_pkg::*; (
  input  logic                   clk,
  input  logic                   reset_i,
  input  logic                   issue_valid_i,
  input  logic [`XLEN-1:0]       issue_pc_i,
  input  logic [`INST_LEN-1:0]   issue_instr_i,
  input  logic                   hold_i,
  output logic                   wb_valid_o,
  output logic [`REG_ADDR_W-1:0] wb_rd_o,
  output logic [`XLEN-1:0]       wb_data_o,
  output logic                   redirect_valid_o,
  output logic [`XLEN-1:0]       redirect_pc_o,
  output logic                   trap_valid_o,
  output logic [`XLEN-1:0]       trap_pc_o
);

  logic [`REG_ADDR_W-1:0] rs1_idx, rs2_idx, d_rd, e_rd, res_rd, fwd_rd, rf_waddr;
  logic [`XLEN-1:0]       rdata1, rdata2, fwd_data, res_data, rf_wdata;
  logic [`XLEN-1:0]       d_pc, d_rs1, d_rs2, d_imm, e_pc, e_rs1, e_rs2, e_imm;
  logic                   d_valid, d_src1pc, d_jal, d_jalr, d_brc, d_wben, d_trap;
  logic                   e_valid, e_src1pc, e_jal, e_jalr, e_brc, e_wben, e_trap;
  logic                   fwd_en, res_valid, res_we, rf_we;
  logic [2:0]             d_funct3, e_funct3;
  alu_op_e                d_aluop, e_aluop;
  src2_sel_e              d_src2sel, e_src2sel;

  reg_file u_reg_file (
    .clk(clk), .reset_i(reset_i), .we_i(rf_we), .waddr_i(rf_waddr), .wdata_i(rf_wdata),
    .raddr1_i(rs1_idx), .raddr2_i(rs2_idx), .rdata1_o(rdata1), .rdata2_o(rdata2)
  );

  id_decode u_id_decode (
    .pc_i(issue_pc_i), .instr_i(issue_instr_i), .valid_i(issue_valid_i),
    .rs1_idx_o(rs1_idx), .rs2_idx_o(rs2_idx), .rdata1_i(rdata1), .rdata2_i(rdata2),
    .fwd_en_i(fwd_en), .fwd_rd_i(fwd_rd), .fwd_data_i(fwd_data),
    .rs1_o(d_rs1), .rs2_o(d_rs2), .imm_o(d_imm), .aluop_o(d_aluop), .src1pc_o(d_src1pc),
    .src2sel_o(d_src2sel), .is_jal_o(d_jal), .is_jalr_o(d_jalr), .is_brc_o(d_brc),
    .brc_funct3_o(d_funct3), .wben_o(d_wben), .rd_o(d_rd), .trap_o(d_trap),
    .valid_o(d_valid), .pc_o(d_pc)
  );

  ex_reg u_ex_reg (
    .clk(clk), .reset_i(reset_i), .stall_i(hold_i), .flush_i(redirect_valid_o),
    .valid_i(d_valid), .pc_i(d_pc), .rs1_i(d_rs1), .rs2_i(d_rs2), .imm_i(d_imm),
    .aluop_i(d_aluop), .src1pc_i(d_src1pc), .src2sel_i(d_src2sel), .is_jal_i(d_jal),
    .is_jalr_i(d_jalr), .is_brc_i(d_brc), .brc_funct3_i(d_funct3), .wben_i(d_wben),
    .rd_i(d_rd), .trap_i(d_trap),
    .valid_o(e_valid), .pc_o(e_pc), .rs1_o(e_rs1), .rs2_o(e_rs2), .imm_o(e_imm),
    .aluop_o(e_aluop), .src1pc_o(e_src1pc), .src2sel_o(e_src2sel), .is_jal_o(e_jal),
    .is_jalr_o(e_jalr), .is_brc_o(e_brc), .brc_funct3_o(e_funct3), .wben_o(e_wben),
    .rd_o(e_rd), .trap_o(e_trap)
  );

  ex_alu u_ex_alu (
    .clk(clk), .reset_i(reset_i),
    .valid_i(e_valid), .pc_i(e_pc), .rs1_i(e_rs1), .rs2_i(e_rs2), .imm_i(e_imm),
    .aluop_i(e_aluop), .src1pc_i(e_src1pc), .src2sel_i(e_src2sel), .is_jal_i(e_jal),
    .is_jalr_i(e_jalr), .is_brc_i(e_brc), .brc_funct3_i(e_funct3), .wben_i(e_wben),
    .rd_i(e_rd), .trap_i(e_trap),
    .res_valid_o(res_valid), .res_rd_o(res_rd), .res_data_o(res_data), .res_we_o(res_we),
    .fwd_en_o(fwd_en), .fwd_rd_o(fwd_rd), .fwd_data_o(fwd_data),
    .redirect_valid_o(redirect_valid_o), .redirect_pc_o(redirect_pc_o),
    .trap_valid_o(trap_valid_o), .trap_pc_o(trap_pc_o)
  );

  wb_stage u_wb_stage (
    .clk(clk), .reset_i(reset_i), .hold_i(hold_i),
    .res_valid_i(res_valid), .res_we_i(res_we), .res_rd_i(res_rd), .res_data_i(res_data),
    .rf_we_o(rf_we), .rf_waddr_o(rf_waddr), .rf_wdata_o(rf_wdata),
    .wb_valid_o(wb_valid_o), .wb_rd_o(wb_rd_o), .wb_data_o(wb_data_o)
  );

endmodule

`default_nettype wire

/* tests/tb_ex_subsys.sv */
`timescale 1ns/1ps
`default_nettype none
`include "core_consts.svh"

module tb_ex_subsys;

  localparam int MAX_CYCLES = 3000;  // 5 reset + 1900 stimulus + drain, with margin

  logic                   clk;
  logic                   reset_i;
  logic                   issue_valid_i;
  logic [`XLEN-1:0]       issue_pc_i;
  logic [`INST_LEN-1:0]   issue_instr_i;
  logic                   hold_i;
  logic                   wb_valid_o;
  logic [`REG_ADDR_W-1:0] wb_rd_o;
  logic [`XLEN-1:0]       wb_data_o;
  logic                   redirect_valid_o;
  logic [`XLEN-1:0]       redirect_pc_o;
  logic                   trap_valid_o;
  logic [`XLEN-1:0]       trap_pc_o;

  integer           seed;
  int               errors;
  int               cycles;
  logic [`XLEN-1:0] model_rf [0:31];
  logic [36:0]      wbq [$];  // {rd, data} in program order
  logic             wb_pending;
  logic [`XLEN-1:0] pc;

  // Instruction sitting in EX, as the model sees it
  logic             ex_v, ex_taken, ex_trap, ex_wr;
  logic [`XLEN-1:0] ex_target, ex_pc;
  // Candidate instruction offered this cycle
  logic             n_taken, n_trap, n_wr;
  logic [4:0]       n_rd;
  logic [`XLEN-1:0] n_res, n_target;

  // Expectations for the current cycle
  logic             exp_wb, exp_redir, exp_trap;
  logic [4:0]       exp_rd;
  logic [`XLEN-1:0] exp_data, exp_redir_pc, exp_trap_pc;

  ex_subsys u_dut (
    .clk(clk), .reset_i(reset_i), .issue_valid_i(issue_valid_i), .issue_pc_i(issue_pc_i),
    .issue_instr_i(issue_instr_i), .hold_i(hold_i), .wb_valid_o(wb_valid_o),
    .wb_rd_o(wb_rd_o), .wb_data_o(wb_data_o), .redirect_valid_o(redirect_valid_o),
    .redirect_pc_o(redirect_pc_o), .trap_valid_o(trap_valid_o), .trap_pc_o(trap_pc_o)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  always @(posedge clk) begin
    cycles = cycles + 1;
    if (cycles > MAX_CYCLES) begin
      $display("Timeout: the run did not finish within %0d cycles", MAX_CYCLES);
      $display("Errors: %0d", errors);
      $display("FAIL: see errors above");
      $finish;
    end
  end

  a_wb_valid: assert property (@(posedge clk) disable iff (reset_i) wb_valid_o == exp_wb)
    else begin
      errors++;
      $display("** Error: wb_valid_o = %h, expected %h", $sampled(wb_valid_o), $sampled(exp_wb));
    end
  a_wb_rd: assert property (@(posedge clk) disable iff (reset_i) exp_wb |-> wb_rd_o == exp_rd)
    else begin
      errors++;
      $display("** Error: wb_rd_o = %h, expected %h", $sampled(wb_rd_o), $sampled(exp_rd));
    end
  a_wb_data: assert property (@(posedge clk) disable iff (reset_i)
    exp_wb |-> wb_data_o == exp_data)
    else begin
      errors++;
      $display("** Error: wb_data_o = %h, expected %h", $sampled(wb_data_o), $sampled(exp_data));
    end
  a_wb_x0: assert property (@(posedge clk) disable iff (reset_i) wb_valid_o |-> wb_rd_o != '0)
    else begin
      errors++;
      $display("** Error: wb_rd_o = %h, expected nonzero", $sampled(wb_rd_o));
    end
  a_redir: assert property (@(posedge clk) disable iff (reset_i) redirect_valid_o == exp_redir)
    else begin
      errors++;
      $display("** Error: redirect_valid_o = %h, expected %h",
               $sampled(redirect_valid_o), $sampled(exp_redir));
    end
  a_redir_pc: assert property (@(posedge clk) disable iff (reset_i)
    exp_redir |-> redirect_pc_o == exp_redir_pc)
    else begin
      errors++;
      $display("** Error: redirect_pc_o = %h, expected %h",
               $sampled(redirect_pc_o), $sampled(exp_redir_pc));
    end
  a_trap: assert property (@(posedge clk) disable iff (reset_i) trap_valid_o == exp_trap)
    else begin
      errors++;
      $display("** Error: trap_valid_o = %h, expected %h",
               $sampled(trap_valid_o), $sampled(exp_trap));
    end
  a_trap_pc: assert property (@(posedge clk) disable iff (reset_i)
    exp_trap |-> trap_pc_o == exp_trap_pc)
    else begin
      errors++;
      $display("** Error: trap_pc_o = %h, expected %h",
               $sampled(trap_pc_o), $sampled(exp_trap_pc));
    end

  // Builds a random instruction and its architectural effect from the current model state
  task automatic make_instr(input int lim);
    logic [31:0] r, r2, a, b, immi, immb, immj;
    logic [4:0]  rd, rs1, rs2;
    logic [2:0]  sel, f3;
    int          kind;
    r    = $random(seed);
    r2   = $random(seed);
    rd   = {2'b0, r[2:0]};
    rs1  = {2'b0, r[5:3]};
    rs2  = {2'b0, r[8:6]};
    sel  = r[11:9];
    a    = model_rf[rs1];
    b    = model_rf[rs2];
    immi = {{20{r[23]}}, r[23:12]};
    immb = {{19{r[23]}}, r[23:12], 1'b0};
    immj = {{11{r2[31]}}, r2[31:12], 1'b0};
    kind = int'(r2[7:0]) % lim;
    n_rd = rd;
    n_wr = 1'b1;
    n_taken = 1'b0;
    n_trap = 1'b0;
    n_target = '0;
    n_res = '0;
    case (kind)
      0: begin
        case (sel)
          3'd0:    {f3, n_res} = {3'b000, a + b};
          3'd1:    {f3, n_res} = {3'b000, a - b};
          3'd2:    {f3, n_res} = {3'b001, a << b[4:0]};
          3'd3:    {f3, n_res} = {3'b010, 31'b0, $signed(a) < $signed(b)};
          3'd4:    {f3, n_res} = {3'b100, a ^ b};
          3'd5:    {f3, n_res} = {3'b101, a >> b[4:0]};
          3'd6:    {f3, n_res} = {3'b110, a | b};
          default: {f3, n_res} = {3'b111, a & b};
        endcase
        issue_instr_i = {(sel == 3'd1) ? 7'h20 : 7'h00, rs2, rs1, f3, rd, 7'h33};
      end
      1: begin
        case (sel)
          3'd0, 3'd1: {f3, n_res} = {3'b000, a + immi};
          3'd2:       {f3, n_res} = {3'b010, 31'b0, $signed(a) < $signed(immi)};
          3'd3:       {f3, n_res} = {3'b100, a ^ immi};
          3'd4, 3'd5: {f3, n_res} = {3'b110, a | immi};
          default:    {f3, n_res} = {3'b111, a & immi};
        endcase
        issue_instr_i = {r[23:12], rs1, f3, rd, 7'h13};
      end
      2: begin
        issue_instr_i = {r2[31:12], rd, 7'h37};
        n_res = {r2[31:12], 12'b0};
      end
      3: begin
        n_wr = 1'b0;
        case (sel[1:0])
          2'd0:    {f3, n_taken} = {3'b000, a == b};
          2'd1:    {f3, n_taken} = {3'b001, a != b};
          2'd2:    {f3, n_taken} = {3'b100, $signed(a) < $signed(b)};
          default: {f3, n_taken} = {3'b101, $signed(a) >= $signed(b)};
        endcase
        issue_instr_i = {immb[12], immb[10:5], rs2, rs1, f3, immb[4:1], immb[11], 7'h63};
        n_target = pc + immb;
      end
      4: begin
        issue_instr_i = {immj[20], immj[10:1], immj[11], immj[19:12], rd, 7'h6f};
        n_taken = 1'b1;
        n_target = pc + immj;
        n_res = pc + 32'd4;
      end
      5: begin
        issue_instr_i = {r[23:12], rs1, 3'b000, rd, 7'h67};
        n_taken = 1'b1;
        n_target = (a + immi) & ~32'd1;
        n_res = pc + 32'd4;
      end
      default: begin
        issue_instr_i = {r2[31:7], 7'h03};  // Load opcode is not implemented
        n_wr = 1'b0;
        n_trap = 1'b1;
      end
    endcase
  endtask

  // One cycle: publish expectations, drive on the falling edge, advance the model
  task automatic step(input int lim, input bit hold_en, input bit valid_en);
    logic accept;
    logic [36:0] head;
    @(negedge clk);
    exp_redir    = ex_v && ex_taken;
    exp_redir_pc = ex_target;
    exp_trap     = ex_v && ex_trap;
    exp_trap_pc  = ex_pc;
    exp_wb       = wb_pending;
    if (wb_pending) begin
      head     = wbq.pop_front();
      exp_rd   = head[36:32];
      exp_data = head[31:0];
    end
    hold_i        = hold_en && (($random(seed) & 3) == 0);
    issue_valid_i = valid_en && (($random(seed) & 7) != 0);
    issue_pc_i    = pc;
    make_instr(lim);
    wb_pending = !hold_i && ex_v && ex_wr;
    accept = issue_valid_i && !hold_i && !(ex_v && ex_taken);
    if (accept) begin
      if (n_wr && n_rd != 5'd0) begin
        model_rf[n_rd] = n_res;
        wbq.push_back({n_rd, n_res});
      end
      ex_v = 1'b1;
      ex_taken = n_taken;
      ex_trap = n_trap;
      ex_wr = n_wr && n_rd != 5'd0;
      ex_target = n_target;
      ex_pc = pc;
      pc = n_taken ? n_target : pc + 32'd4;
    end else if (!hold_i) begin
      ex_v = 1'b0;
    end
  endtask

  initial begin
    seed = 32'h8cce3688;
    errors = 0;
    cycles = 0;
    reset_i = 1'b1;
    issue_valid_i = 1'b0;
    issue_pc_i = '0;
    issue_instr_i = '0;
    hold_i = 1'b0;
    for (int k = 0; k < 32; k++) model_rf[k] = '0;
    wb_pending = 1'b0;
    pc = 32'h0000_1000;
    ex_v = 1'b0;
    ex_taken = 1'b0;
    ex_trap = 1'b0;
    ex_wr = 1'b0;
    ex_target = '0;
    ex_pc = '0;
    exp_wb = 1'b0;
    exp_redir = 1'b0;
    exp_trap = 1'b0;
    exp_rd = '0;
    exp_data = '0;
    exp_redir_pc = '0;
    exp_trap_pc = '0;
    repeat (5) @(posedge clk);
    @(negedge clk);
    reset_i = 1'b0;
    repeat (500) step(3, 1'b0, 1'b1);  // ALU, immediate and LUI
    repeat (700) step(6, 1'b0, 1'b1);  // Adds branches and jumps
    repeat (700) step(7, 1'b1, 1'b1);  // Adds illegal opcodes and hold pulses
    while (wbq.size() != 0 || wb_pending) step(3, 1'b0, 1'b0);
    repeat (3) step(3, 1'b0, 1'b0);
    @(posedge clk);
    #1;
    $display("Errors: %0d", errors);
    if (errors == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* compile.f */
+incdir+hw
hw/core_pkg.sv
hw/reg_file.sv
hw/id_decode.sv
hw/ex_reg.sv
hw/ex_alu.sv
hw/wb_stage.sv
hw/ex_subsys.sv
tests/tb_ex_subsys.sv

/* run.sh */
#!/bin/sh
# Build and run the testbench with Verilator, then look for the pass line in the log
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f compile.f --top-module tb_ex_subsys -o sim_tb \
  && ./obj_dir/sim_tb > sim.log 2>&1 \
  ; cat sim.log 2>/dev/null

grep -q "^PASS: all tests$" sim.log 2>/dev/null \
  && echo "Simulation passed" \
  || { echo "Simulation failed"; exit 1; }
